// ==== compile.f ====
src/sched_pkg.sv
src/stream_fifo.sv
src/slot_keeper.sv
src/ctrl_msg_decoder.sv
src/desc_allocator.sv
src/sched_csr.sv
src/desc_scheduler.sv
verification/tb_desc_scheduler.sv

// ==== verification/sched_input.txt ====
# Command then hex operands: I core n, R core slot, H port hash, D core desc, W adr data,
# Q adr expected, S drain, B random ready on/off, E test name
Q 0 f
Q 1 0
Q 4 0
Q 8 0
Q 9 0
E reset_values
I 1 3
H 0 1
H 1 5
S
Q 5 1
E slot_init
H 0 9
H 0 d
S
Q 8 1
R 1 2
H 1 11
S
Q 5 0
I 2 8
R 2 3
Q 1 1
W 1 1
Q 1 0
E no_slot_drop
W 0 b
H 0 2
H 1 6
S
Q 6 8
Q 8 2
Q 9 1
E mask_drop
B 1
D 0 12340001
D 3 abcd0002
D 1 00000003
D 2 ffff0004
D 3 55550005
D 0 00000006
S
E done_forward
W 0 f
I 0 4
I 3 2
H 0 10
H 1 21
H 0 23
H 1 2a
H 0 4
H 1 30
H 0 7
H 1 44
H 0 7f
H 1 b
S
Q 4 0
Q 6 7
Q 7 0
E random_alloc

// ==== verification/tb_desc_scheduler.sv ====
`timescale 1ns/1ps

module tb_desc_scheduler;

  import sched_pkg::*;

  logic                            clk;
  logic                            rst_r;
  logic [if_count-1:0]             hash_in_valid;
  logic [if_count-1:0]             hash_in_ready;
  logic [if_count-1:0][hash_w-1:0] hash_in;
  logic                            ctrl_in_valid;
  logic                            ctrl_in_ready;
  ctrl_msg_t                       ctrl_in;
  logic                            alloc_valid;
  logic                            alloc_ready;
  alloc_t                          alloc;
  logic                            ctrl_out_valid;
  logic                            ctrl_out_ready;
  ctrl_msg_t                       ctrl_out;
  wb_req_t                         wb_req;
  wb_rsp_t                         wb_rsp;

  // Reference model entries are tagged with their port or core
  logic [if_w+hash_w-1:0]   exp_hash_q [$];
  logic [core_w+slot_w-1:0] free_q [$];
  ctrl_msg_t                exp_done [$];
  logic [core_count-1:0]    mask_m;
  int                       drop_m [if_count];

  string lines [$];
  logic  rand_ready;
  int    cycles;
  int    limit;
  int    errors;
  int    test_errors;
  int    tests;
  int    tests_failed;

  desc_scheduler dut0 (
    .clk            (clk),
    .rst_r          (rst_r),
    .hash_in_valid  (hash_in_valid),
    .hash_in_ready  (hash_in_ready),
    .hash_in        (hash_in),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_in        (ctrl_in),
    .alloc_valid    (alloc_valid),
    .alloc_ready    (alloc_ready),
    .alloc          (alloc),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready),
    .ctrl_out       (ctrl_out),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
  end

  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
    end
    $display("Timeout, the run was still busy after %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  // Output ready lines toggle randomly only while enabled
  always @(posedge clk) begin
    #1;
    alloc_ready    = rand_ready ? 1'($urandom % 2) : 1'b1;
    ctrl_out_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    errors++;
    test_errors++;
    $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
  endtask

  task automatic note_error(input string msg);
    errors++;
    test_errors++;
    $display("ERROR %s", msg);
  endtask

  function automatic string strip(input string s);
    string r;
    r = s;
    while (r.len() > 0 && (r.getc(r.len() - 1) == 8'h0a || r.getc(r.len() - 1) == 8'h0d ||
                           r.getc(r.len() - 1) == 8'h20)) begin
      r = r.substr(0, r.len() - 2);
    end
    return r;
  endfunction

  function automatic int free_count(input int core);
    int n;
    n = 0;
    foreach (free_q[i]) begin
      if (free_q[i][slot_w +: core_w] == core_w'(core)) begin
        n++;
      end
    end
    return n;
  endfunction

  // Loads slots 1 to n clipped to the keeper size
  task automatic init_model(input int core, input int n);
    int k;
    for (int i = free_q.size() - 1; i >= 0; i--) begin
      if (free_q[i][slot_w +: core_w] == core_w'(core)) begin
        free_q.delete(i);
      end
    end
    k = (n > slot_count) ? slot_count : n;
    for (int s = 1; s <= k; s++) begin
      free_q.push_back({core_w'(core), slot_w'(s)});
    end
  endtask

  task automatic send_hash(input int port, input logic [hash_w-1:0] h);
    hash_in[port]       = h;
    hash_in_valid[port] = 1'b1;
    @(negedge clk);
    while (!hash_in_ready[port]) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    hash_in_valid[port] = 1'b0;
    exp_hash_q.push_back({if_w'(port), h});
  endtask

  task automatic send_ctrl(input logic [msg_type_w-1:0] t, input int core,
                           input logic [desc_w-1:0] desc);
    ctrl_in.msg_type = t;
    ctrl_in.src      = core_w'(core);
    ctrl_in.desc     = desc;
    ctrl_in_valid    = 1'b1;
    @(negedge clk);
    while (!ctrl_in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    ctrl_in_valid = 1'b0;
    // Strobe and keeper update settle before the next command
    repeat (3) @(posedge clk);
    #1;
  endtask

  task automatic wb_access(input logic we, input logic [adr_w-1:0] adr,
                           input logic [dat_w-1:0] dat, output logic [dat_w-1:0] rdata);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge clk);
    while (!wb_rsp.ack) begin
      @(negedge clk);
    end
    rdata = wb_rsp.dat;
    @(posedge clk);
    #1;
    wb_req = '0;
  endtask

  task automatic drain();
    while (exp_hash_q.size() != 0 || exp_done.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  always @(negedge clk) begin
    int                idx;
    logic [hash_w-1:0] h;
    logic [core_w-1:0] c;
    logic [slot_w-1:0] exp_slot;
    logic              exp_drop;
    if (!rst_r && alloc_valid && alloc_ready) begin
      idx = -1;
      for (int i = exp_hash_q.size() - 1; i >= 0; i--) begin
        if (exp_hash_q[i][hash_w +: if_w] == alloc.port) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        note_error($sformatf("result on port %0d with no hash pending", alloc.port));
      end else begin
        h = exp_hash_q[idx][hash_w-1:0];
        exp_hash_q.delete(idx);
        c = h[hash_sel_lsb +: core_w];
        idx = -1;
        for (int i = free_q.size() - 1; i >= 0; i--) begin
          if (free_q[i][slot_w +: core_w] == c) begin
            idx = i;
          end
        end
        if (mask_m[c] && idx >= 0) begin
          exp_slot = free_q[idx][slot_w-1:0];
          exp_drop = 1'b0;
          free_q.delete(idx);
        end else begin
          exp_slot = '0;
          exp_drop = 1'b1;
          drop_m[alloc.port]++;
        end
        if (alloc.hash !== h) begin
          report_mismatch("alloc.hash", h, alloc.hash);
        end
        if (alloc.core !== c) begin
          report_mismatch("alloc.core", c, alloc.core);
        end
        if (alloc.slot !== exp_slot) begin
          report_mismatch("alloc.slot", exp_slot, alloc.slot);
        end
        if (alloc.drop !== exp_drop) begin
          report_mismatch("alloc.drop", exp_drop, alloc.drop);
        end
      end
    end
  end

  always @(negedge clk) begin
    ctrl_msg_t e;
    if (!rst_r && ctrl_out_valid && ctrl_out_ready) begin
      if (exp_done.size() == 0) begin
        note_error("send-out message with none expected");
      end else begin
        e = exp_done.pop_front();
        if (ctrl_out.msg_type !== e.msg_type) begin
          report_mismatch("ctrl_out.msg_type", e.msg_type, ctrl_out.msg_type);
        end
        if (ctrl_out.src !== e.src) begin
          report_mismatch("ctrl_out.src", e.src, ctrl_out.src);
        end
        if (ctrl_out.desc !== e.desc) begin
          report_mismatch("ctrl_out.desc", e.desc, ctrl_out.desc);
        end
      end
    end
  end

  initial begin
    int               fd;
    string            line;
    string            name;
    byte              cmd;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [dat_w-1:0] rd;
    void'($urandom(85));
    rst_r          = 1'b1;
    hash_in_valid  = '0;
    hash_in        = '0;
    ctrl_in_valid  = 1'b0;
    ctrl_in        = '0;
    alloc_ready    = 1'b1;
    ctrl_out_ready = 1'b1;
    wb_req         = '0;
    rand_ready     = 1'b0;
    mask_m         = '1;
    foreach (drop_m[i]) begin
      drop_m[i] = 0;
    end
    fd = $fopen("verification/sched_input.txt", "r");
    if (fd == 0) begin
      note_error("could not open verification/sched_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        line = strip(line);
        if (line.len() > 0 && line.getc(0) != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    limit = 200 * ((lines.size() > 0) ? lines.size() : 1);

    repeat (5) @(posedge clk);
    #1;
    rst_r = 1'b0;
    if (alloc_valid !== 1'b0) begin
      report_mismatch("alloc_valid", 0, alloc_valid);
    end
    if (ctrl_out_valid !== 1'b0) begin
      report_mismatch("ctrl_out_valid", 0, ctrl_out_valid);
    end

    foreach (lines[i]) begin
      cmd = lines[i].getc(0);
      a   = '0;
      b   = '0;
      if (cmd != "E" && lines[i].len() > 1) begin
        void'($sscanf(lines[i].substr(1, lines[i].len() - 1), "%h %h", a, b));
      end
      case (cmd)
        "I": begin
          send_ctrl(msg_slot_init, a, b << slot_field_lsb);
          init_model(a, b);
        end
        "R": begin
          send_ctrl(msg_slot_ret, a, b << slot_field_lsb);
          if (b != 0 && free_count(a) < slot_count) begin
            free_q.push_back({core_w'(a), slot_w'(b)});
          end
        end
        "H": send_hash(a, b);
        "D": begin
          // The send-out can appear before the message handshake finishes
          exp_done.push_back({msg_send_out, core_w'(a), b});
          send_ctrl(msg_pkt_done, a, b);
        end
        "W": begin
          wb_access(1'b1, a[adr_w-1:0], b, rd);
          if (a[adr_w-1:0] == reg_income_mask) begin
            mask_m = b[core_count-1:0];
          end
        end
        "Q": begin
          wb_access(1'b0, a[adr_w-1:0], '0, rd);
          if (rd !== b) begin
            report_mismatch($sformatf("wb_rsp.dat at 0x%0h", a), b, rd);
          end
          // Drop counters are also held against the model
          if (a >= reg_drop_count_base && a < reg_drop_count_base + if_count) begin
            if (rd !== drop_m[a - reg_drop_count_base]) begin
              report_mismatch("drop_count", drop_m[a - reg_drop_count_base], rd);
            end
          end
        end
        "S": drain();
        "B": rand_ready = a[0];
        "E": begin
          name = strip(lines[i].substr(2, lines[i].len() - 1));
          tests++;
          if (test_errors == 0) begin
            $display("test %s: ok", name);
          end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
          end
          test_errors = 0;
        end
        default: note_error($sformatf("unknown command line '%s'", lines[i]));
      endcase
    end

    drain();
    $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== src/desc_scheduler.sv ====
`timescale 1ns/1ps

module desc_scheduler (
  input  logic                                                 clk,
  input  logic                                                 rst_r,
  input  logic [sched_pkg::if_count-1:0]                       hash_in_valid,
  output logic [sched_pkg::if_count-1:0]                       hash_in_ready,
  input  logic [sched_pkg::if_count-1:0][sched_pkg::hash_w-1:0] hash_in,
  input  logic                                                 ctrl_in_valid,
  output logic                                                 ctrl_in_ready,
  input  sched_pkg::ctrl_msg_t                                 ctrl_in,
  output logic                                                 alloc_valid,
  input  logic                                                 alloc_ready,
  output sched_pkg::alloc_t                                    alloc,
  output logic                                                 ctrl_out_valid,
  input  logic                                                 ctrl_out_ready,
  output sched_pkg::ctrl_msg_t                                 ctrl_out,
  input  sched_pkg::wb_req_t                                   wb_req,
  output sched_pkg::wb_rsp_t                                   wb_rsp
);

  import sched_pkg::*;

  logic [if_count-1:0]               hash_q_valid;
  logic [if_count-1:0]               hash_q_pop;
  logic [if_count-1:0][hash_w-1:0]   hash_q_data;
  logic [core_count-1:0]             enq_strobe;
  logic [core_count-1:0]             init_strobe;
  logic [slot_w-1:0]                 slot_value;
  logic [core_count-1:0]             slot_pop;
  logic [core_count-1:0][slot_w-1:0] head_slot;
  logic [core_count-1:0]             nonempty;
  logic [core_count-1:0][slot_w-1:0] slot_count_w;
  logic [core_count-1:0]             keeper_err;
  logic [core_count-1:0]             income_mask;
  logic [if_count-1:0][drop_w-1:0]   drop_count;

  // One hash queue per interface
  for (genvar g = 0; g < if_count; g++) begin : g_hash_q
    stream_fifo #(
      .payload_t (logic [hash_w-1:0]),
      .depth     (hash_fifo_depth)
    ) hash_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (hash_in_valid[g]),
      .in_ready  (hash_in_ready[g]),
      .in_data   (hash_in[g]),
      .out_valid (hash_q_valid[g]),
      .out_ready (hash_q_pop[g]),
      .out_data  (hash_q_data[g])
    );
  end

  ctrl_msg_decoder decoder (
    .clk            (clk),
    .rst_r          (rst_r),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_in        (ctrl_in),
    .enq_strobe     (enq_strobe),
    .init_strobe    (init_strobe),
    .slot_value     (slot_value),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready),
    .ctrl_out       (ctrl_out)
  );

  for (genvar c = 0; c < core_count; c++) begin : g_keeper
    slot_keeper keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .init_valid (init_strobe[c]),
      .enq_valid  (enq_strobe[c]),
      .pop        (slot_pop[c]),
      .slot_in    (slot_value),
      .head_slot  (head_slot[c]),
      .nonempty   (nonempty[c]),
      .count      (slot_count_w[c]),
      .err        (keeper_err[c])
    );
  end

  desc_allocator allocator (
    .clk         (clk),
    .rst_r       (rst_r),
    .req_valid   (hash_q_valid),
    .req_pop     (hash_q_pop),
    .req_hash    (hash_q_data),
    .income_mask (income_mask),
    .head_slot   (head_slot),
    .nonempty    (nonempty),
    .slot_pop    (slot_pop),
    .alloc_valid (alloc_valid),
    .alloc_ready (alloc_ready),
    .alloc       (alloc),
    .drop_count  (drop_count)
  );

  sched_csr csr (
    .clk         (clk),
    .rst_r       (rst_r),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .slot_err    (|keeper_err),
    .slot_counts (slot_count_w),
    .drop_counts (drop_count),
    .income_mask (income_mask)
  );

endmodule

// ==== src/sched_csr.sv ====
`timescale 1ns/1ps

module sched_csr (
  input  logic                                                    clk,
  input  logic                                                    rst_r,
  input  sched_pkg::wb_req_t                                      wb_req,
  output sched_pkg::wb_rsp_t                                      wb_rsp,
  input  logic                                                    slot_err,
  input  logic [sched_pkg::core_count-1:0][sched_pkg::slot_w-1:0] slot_counts,
  input  logic [sched_pkg::if_count-1:0][sched_pkg::drop_w-1:0]   drop_counts,
  output logic [sched_pkg::core_count-1:0]                        income_mask
);

  import sched_pkg::*;

  logic             ack_r;
  logic [dat_w-1:0] rd_data;
  logic [dat_w-1:0] rd_next;
  logic             err_sticky;
  logic             req;

  // One access per strobe, the ack cycle blocks a second one
  assign req = wb_req.cyc && wb_req.stb && !ack_r;

  always_comb begin
    rd_next = '0;
    if (wb_req.adr == reg_income_mask) begin
      rd_next[core_count-1:0] = income_mask;
    end
    if (wb_req.adr == reg_slot_err) begin
      rd_next[0] = err_sticky;
    end
    for (int i = 0; i < core_count; i++) begin
      if (wb_req.adr == adr_w'(reg_slot_count_base + i)) begin
        rd_next[slot_w-1:0] = slot_counts[i];
      end
    end
    for (int i = 0; i < if_count; i++) begin
      if (wb_req.adr == adr_w'(reg_drop_count_base + i)) begin
        rd_next[drop_w-1:0] = drop_counts[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      ack_r       <= 1'b0;
      income_mask <= '1;
      err_sticky  <= 1'b0;
    end else begin
      ack_r <= req;
      if (req && wb_req.we && wb_req.adr == reg_income_mask) begin
        income_mask <= wb_req.dat[core_count-1:0];
      end
      // New error wins over a clear in the same cycle
      if (slot_err) begin
        err_sticky <= 1'b1;
      end else if (req && wb_req.we && wb_req.adr == reg_slot_err && wb_req.dat[0]) begin
        err_sticky <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      rd_data <= rd_next;
    end
  end

  assign wb_rsp.ack = ack_r;
  assign wb_rsp.dat = rd_data;

endmodule

// ==== src/desc_allocator.sv ====
`timescale 1ns/1ps

module desc_allocator (
  input  logic                                                     clk,
  input  logic                                                     rst_r,
  input  logic [sched_pkg::if_count-1:0]                           req_valid,
  output logic [sched_pkg::if_count-1:0]                           req_pop,
  input  logic [sched_pkg::if_count-1:0][sched_pkg::hash_w-1:0]    req_hash,
  input  logic [sched_pkg::core_count-1:0]                         income_mask,
  input  logic [sched_pkg::core_count-1:0][sched_pkg::slot_w-1:0]  head_slot,
  input  logic [sched_pkg::core_count-1:0]                         nonempty,
  output logic [sched_pkg::core_count-1:0]                         slot_pop,
  output logic                                                     alloc_valid,
  input  logic                                                     alloc_ready,
  output sched_pkg::alloc_t                                        alloc,
  output logic [sched_pkg::if_count-1:0][sched_pkg::drop_w-1:0]    drop_count
);

  import sched_pkg::*;

  logic              grant_v;
  logic [if_w-1:0]   grant_if;
  logic [if_w-1:0]   last_if;
  logic              stall;
  logic              s1_valid;
  logic [if_w-1:0]   s1_port;
  logic [hash_w-1:0] s1_hash;
  logic [core_w-1:0] s2_core;
  logic              s2_ok;
  logic              s2_fire;

  // A held result freezes both stages
  assign stall = alloc_valid && !alloc_ready;

  // Round-robin search starting after the last winner
  always_comb begin
    int idx;
    grant_v  = 1'b0;
    grant_if = last_if;
    for (int k = 1; k <= if_count; k++) begin
      idx = (int'(last_if) + k) % if_count;
      if (!grant_v && req_valid[idx]) begin
        grant_v  = 1'b1;
        grant_if = if_w'(idx);
      end
    end
  end

  always_comb begin
    req_pop           = '0;
    req_pop[grant_if] = grant_v && !stall;
  end

  // Stage one
  always_ff @(posedge clk) begin
    if (rst_r) begin
      s1_valid <= 1'b0;
      last_if  <= '0;
    end else if (!stall) begin
      s1_valid <= grant_v;
      if (grant_v) begin
        last_if <= grant_if;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && grant_v) begin
      s1_port <= grant_if;
      s1_hash <= req_hash[grant_if];
    end
  end

  // Stage two picks the core from the hash and takes a slot or drops
  assign s2_core = s1_hash[hash_sel_lsb +: core_w];
  assign s2_ok   = nonempty[s2_core] && income_mask[s2_core];
  assign s2_fire = s1_valid && !stall;

  always_comb begin
    slot_pop          = '0;
    slot_pop[s2_core] = s2_fire && s2_ok;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      alloc_valid <= 1'b0;
      drop_count  <= '0;
    end else begin
      if (!stall) begin
        alloc_valid <= s1_valid;
      end
      if (s2_fire && !s2_ok) begin
        drop_count[s1_port] <= drop_count[s1_port] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2_fire) begin
      alloc.port <= s1_port;
      alloc.hash <= s1_hash;
      alloc.core <= s2_core;
      alloc.slot <= s2_ok ? head_slot[s2_core] : '0;
      alloc.drop <= !s2_ok;
    end
  end

  // A granted slot is never the reserved slot 0
  a_slot_nonzero: assert property (@(posedge clk) disable iff (rst_r)
    s2_fire && s2_ok |-> head_slot[s2_core] != '0);

endmodule

// ==== src/ctrl_msg_decoder.sv ====
`timescale 1ns/1ps

module ctrl_msg_decoder (
  input  logic                             clk,
  input  logic                             rst_r,
  input  logic                             ctrl_in_valid,
  output logic                             ctrl_in_ready,
  input  sched_pkg::ctrl_msg_t             ctrl_in,
  output logic [sched_pkg::core_count-1:0] enq_strobe,
  output logic [sched_pkg::core_count-1:0] init_strobe,
  output logic [sched_pkg::slot_w-1:0]     slot_value,
  output logic                             ctrl_out_valid,
  input  logic                             ctrl_out_ready,
  output sched_pkg::ctrl_msg_t             ctrl_out
);

  import sched_pkg::*;

  logic      is_done;
  ctrl_msg_t done_msg;
  logic      done_in_ready;
  logic      done_valid;
  ctrl_msg_t done_head;
  logic      done_take;

  assign is_done = (ctrl_in.msg_type == msg_pkt_done);

  // Slot messages never wait, unknown types are consumed and ignored
  assign ctrl_in_ready = is_done ? done_in_ready : 1'b1;

  // Packet done goes back out as send-out, src names the destination core
  always_comb begin
    done_msg          = ctrl_in;
    done_msg.msg_type = msg_send_out;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enq_strobe  <= '0;
      init_strobe <= '0;
    end else begin
      for (int i = 0; i < core_count; i++) begin
        enq_strobe[i]  <= ctrl_in_valid && (ctrl_in.msg_type == msg_slot_ret) &&
                          (ctrl_in.src == core_w'(i));
        init_strobe[i] <= ctrl_in_valid && (ctrl_in.msg_type == msg_slot_init) &&
                          (ctrl_in.src == core_w'(i));
      end
    end
  end

  // Slot number or init count, aligned with the strobes
  always_ff @(posedge clk) begin
    slot_value <= ctrl_in.desc[slot_field_lsb +: slot_w];
  end

  stream_fifo #(
    .payload_t (ctrl_msg_t),
    .depth     (done_fifo_depth)
  ) done_fifo (
    .clk       (clk),
    .rst_r     (rst_r),
    .in_valid  (ctrl_in_valid && is_done),
    .in_ready  (done_in_ready),
    .in_data   (done_msg),
    .out_valid (done_valid),
    .out_ready (!ctrl_out_valid || ctrl_out_ready),
    .out_data  (done_head)
  );

  assign done_take = done_valid && (!ctrl_out_valid || ctrl_out_ready);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      ctrl_out_valid <= 1'b0;
    end else if (done_take) begin
      ctrl_out_valid <= 1'b1;
    end else if (ctrl_out_ready) begin
      ctrl_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (done_take) begin
      ctrl_out <= done_head;
    end
  end

endmodule

// ==== src/slot_keeper.sv ====
`timescale 1ns/1ps

module slot_keeper (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic                         init_valid,
  input  logic                         enq_valid,
  input  logic                         pop,
  input  logic [sched_pkg::slot_w-1:0] slot_in,
  output logic [sched_pkg::slot_w-1:0] head_slot,
  output logic                         nonempty,
  output logic [sched_pkg::slot_w-1:0] count,
  output logic                         err
);

  import sched_pkg::*;

  logic [slot_w-1:0]     slots [slot_count];
  logic [slot_ptr_w-1:0] rd_ptr;
  logic [slot_ptr_w-1:0] wr_ptr;
  logic [slot_w-1:0]     init_n;
  logic                  full;
  logic                  enq_ok;

  // Init count larger than the keeper is clipped
  assign init_n    = (slot_in > slot_w'(slot_count)) ? slot_w'(slot_count) : slot_in;
  assign full      = (count == slot_w'(slot_count));
  assign enq_ok    = enq_valid && !full && (slot_in != '0);
  assign nonempty  = (count != '0);
  assign head_slot = slots[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      err    <= 1'b0;
    end else begin
      err <= enq_valid && (full || slot_in == '0);
      if (init_valid) begin
        rd_ptr <= '0;
        wr_ptr <= init_n[slot_ptr_w-1:0];
        count  <= init_n;
      end else begin
        if (pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        if (enq_ok) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        count <= count + slot_w'(enq_ok) - slot_w'(pop);
      end
    end
  end

  // Init fills every entry, only the first n count
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < slot_count; i++) begin
        slots[i] <= slot_w'(i + 1);
      end
    end else if (enq_ok) begin
      slots[wr_ptr] <= slot_in;
    end
  end

  // Allocator only pops a core it saw as nonempty
  a_pop_nonempty: assert property (@(posedge clk) disable iff (rst_r)
    pop |-> nonempty);

endmodule

// ==== src/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = sched_pkg::hash_fifo_depth
) (
  input  logic     clk,
  input  logic     rst_r,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t                   mem [depth];
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       push;
  logic                       pull;

  assign in_ready  = (count != depth);
  assign out_valid = (count != 0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pull      = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pull) begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pull) begin
        count <= count + 1'b1;
      end else if (!push && pull) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // An entry offered to a full buffer waits unchanged until there is room
  a_no_push_full: assert property (@(posedge clk) disable iff (rst_r)
    in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

// ==== src/sched_pkg.sv ====
package sched_pkg;

  localparam int core_count = 4;
  localparam int if_count   = 2;
  localparam int slot_count = 8;

  localparam int core_w     = 2;
  localparam int if_w       = 1;
  localparam int slot_w     = 4;
  localparam int slot_ptr_w = 3;
  localparam int hash_w     = 32;
  localparam int drop_w     = 16;
  localparam int adr_w      = 4;
  localparam int dat_w      = 32;

  // Lowest hash bit of the core select field
  localparam int hash_sel_lsb = 0;

  localparam int msg_type_w     = 4;
  localparam int desc_w         = 32;
  localparam int slot_field_lsb = 16;

  // Send-out shares code 0 with slot return, they travel in opposite directions
  localparam logic [msg_type_w-1:0] msg_slot_ret  = 4'd0;
  localparam logic [msg_type_w-1:0] msg_pkt_done  = 4'd1;
  localparam logic [msg_type_w-1:0] msg_slot_init = 4'd3;
  localparam logic [msg_type_w-1:0] msg_send_out  = 4'd0;

  localparam int hash_fifo_depth = 4;
  localparam int done_fifo_depth = 4;

  // Word addresses of the host registers
  localparam logic [adr_w-1:0] reg_income_mask     = 4'd0;
  localparam logic [adr_w-1:0] reg_slot_err        = 4'd1;
  localparam logic [adr_w-1:0] reg_slot_count_base = 4'd4;
  localparam logic [adr_w-1:0] reg_drop_count_base = 4'd8;

  typedef struct packed {
    logic [msg_type_w-1:0] msg_type;
    logic [core_w-1:0]     src;
    logic [desc_w-1:0]     desc;
  } ctrl_msg_t;

  typedef struct packed {
    logic [if_w-1:0]   port;
    logic [hash_w-1:0] hash;
    logic [core_w-1:0] core;
    logic [slot_w-1:0] slot;
    logic              drop;
  } alloc_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [adr_w-1:0] adr;
    logic [dat_w-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [dat_w-1:0] dat;
  } wb_rsp_t;

endpackage
